/* Makefile */
# Verilator build and run for the renaming core slice
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= core_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* core_top.f */
verilog/core_pkg.sv
verilog/rename_stage.sv
verilog/issue_execute.sv
verilog/reorder_buffer.sv
verilog/core_top.sv
tests/core_sva.sv
tests/core_checker.sv
tests/core_tb.sv

/* tests/core_checker.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// architectural model of the core, compares commits in program order
// all arch registers start at zero after reset
//////////////////////////////////////////////////////////////////////

module core_checker import core_pkg::*; (
  input  wire                      clock,
  input  wire                      reset,
  input  wire                      inst_valid,
  input  wire opcode_e             inst_opcode,
  input  wire [arch_idx_width-1:0] inst_dest,
  input  wire [arch_idx_width-1:0] inst_src1,
  input  wire [arch_idx_width-1:0] inst_src2,
  input  wire [imm_width-1:0]      inst_imm,
  input  wire                      stall,
  input  wire                      commit_valid,
  input  wire [arch_idx_width-1:0] commit_arch_idx,
  input  wire [data_width-1:0]     commit_data,
  output int                       error_count,
  output int                       accept_count,
  output int                       commit_count,
  output int                       pending        // accepted, not yet committed
);

  logic [data_width-1:0]     arch_model [arch_regs];
  logic [arch_idx_width-1:0] exp_dest [$];          // program order
  logic [data_width-1:0]     exp_data [$];
  logic [arch_idx_width-1:0] want_dest;
  logic [data_width-1:0]     want_data;

  // result by opcode, everything wraps at data_width
  function automatic logic [data_width-1:0] exec_op(input opcode_e op,
      input logic [data_width-1:0] a, input logic [data_width-1:0] b,
      input logic [imm_width-1:0] imm);
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_xor:  return a ^ b;
      op_li:   return data_width'(imm);   // zero extended
      default: return a * b;              // low half only
    endcase
  endfunction

  always @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < arch_regs; r++) begin
        arch_model[r] = '0;
      end
      exp_dest.delete();
      exp_data.delete();
      error_count  = 0;
      accept_count = 0;
      commit_count = 0;
    end else begin
      if (commit_valid) begin
        commit_count++;
        if (exp_dest.size() == 0) begin
          $display("commit seen with no instruction outstanding");
          error_count++;
        end else begin
          want_dest = exp_dest.pop_front();
          want_data = exp_data.pop_front();
          if (commit_arch_idx !== want_dest) begin
            $display("error commit_arch_idx got %h expected %h", commit_arch_idx, want_dest);
            error_count++;
          end
          if (commit_data !== want_data) begin
            $display("error commit_data got %h expected %h", commit_data, want_data);
            error_count++;
          end
        end
      end
      if (inst_valid && !stall) begin   // taken this edge
        want_data = exec_op(inst_opcode, arch_model[inst_src1], arch_model[inst_src2],
                            inst_imm);
        arch_model[inst_dest] = want_data;
        exp_dest.push_back(inst_dest);
        exp_data.push_back(want_data);
        accept_count++;
      end
    end
    pending = exp_dest.size();
  end

endmodule

`default_nettype wire

/* tests/core_sva.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// bus and reorder buffer assertions, bound into two modules
// ports unused by one target are tied off in its bind
//////////////////////////////////////////////////////////////////////

module core_sva import core_pkg::*; (
  input wire                       clock,
  input wire                       reset,
  input wire                       alu_done,      // alu result on the bus
  input wire                       mul_done,      // multiply result on the bus
  input wire [rob_count_width-1:0] rob_count,
  input wire                       commit_valid
);

  int fail_count = 0;   // read by the testbench at the end

  one_result: assert property (@(posedge clock) disable iff (reset)
    !(alu_done && mul_done))
    else begin
      $error("alu and multiply drive the result bus together");
      fail_count++;
    end

  rob_bound: assert property (@(posedge clock) disable iff (reset)
    rob_count <= rob_count_width'(rob_depth))
    else begin
      $error("reorder buffer count above depth");
      fail_count++;
    end

  // first cycle out of reset
  quiet_start: assert property (@(posedge clock) $fell(reset) |-> !commit_valid)
    else begin
      $error("commit right after reset");
      fail_count++;
    end

endmodule

bind issue_execute core_sva sva_i (
  .clock, .reset,
  .alu_done(alu_valid), .mul_done(mul_valid[mul_latency-1]),
  .rob_count('0), .commit_valid(1'b0)
);

bind reorder_buffer core_sva sva_i (
  .clock, .reset,
  .alu_done(1'b0), .mul_done(1'b0),
  .rob_count(count), .commit_valid
);

`default_nettype wire

/* tests/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// seeded random instruction stream for core_top, 4 ns clock
// registers 0..3 only, so dependencies are dense
// periodic multiply bursts fill the reorder buffer
//////////////////////////////////////////////////////////////////////

module core_tb import core_pkg::*; ();

  localparam int num_insts     = 400;
  localparam int reset_cycles  = 8;
  localparam int stall_timeout = 200;   // cycles per offered instruction
  localparam int drain_timeout = 500;

  logic                      clock;
  logic                      reset;
  logic                      inst_valid;
  opcode_e                   inst_opcode;
  logic [arch_idx_width-1:0] inst_dest, inst_src1, inst_src2;
  logic [imm_width-1:0]      inst_imm;
  wire                       stall;
  wire                       commit_valid;
  wire [arch_idx_width-1:0]  commit_arch_idx;
  wire [data_width-1:0]      commit_data;
  int                        chk_errors, accept_count, commit_count, pending;
  integer                    seed;

  initial clock = 1'b0;
  always #2 clock = ~clock;

  core_top core_top_i (
    .clock, .reset,
    .inst_valid, .inst_opcode, .inst_dest, .inst_src1, .inst_src2, .inst_imm,
    .stall, .commit_valid, .commit_arch_idx, .commit_data
  );

  core_checker checker_i (
    .clock, .reset,
    .inst_valid, .inst_opcode, .inst_dest, .inst_src1, .inst_src2, .inst_imm,
    .stall, .commit_valid, .commit_arch_idx, .commit_data,
    .error_count(chk_errors), .accept_count, .commit_count, .pending
  );

  // called on a falling edge, returns just after the accepting edge
  task automatic offer_inst(input opcode_e op, input int d, input int s1, input int s2,
                            output bit timed_out);
    int waited;
    waited      = 0;
    timed_out   = 1'b0;
    inst_valid  = 1'b1;
    inst_opcode = op;
    inst_dest   = arch_idx_width'(d);
    inst_src1   = arch_idx_width'(s1);
    inst_src2   = arch_idx_width'(s2);
    inst_imm    = imm_width'($random(seed));
    while (stall && waited < stall_timeout) begin   // hold while stalled
      @(negedge clock);
      waited++;
    end
    if (stall) timed_out = 1'b1;
    else @(posedge clock);
  endtask

  initial begin : stimulus
    int  tb_errors;
    int  sva_errors;
    int  waited;
    int  r;
    bit  burst;
    bit  timed_out;
    opcode_e op;
    tb_errors   = 0;
    timed_out   = 1'b0;
    seed        = 66115;
    reset       = 1'b1;
    inst_valid  = 1'b0;
    inst_opcode = op_add;
    inst_dest   = '0;
    inst_src1   = '0;
    inst_src2   = '0;
    inst_imm    = '0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // idle core, nothing offered yet
    repeat (3) begin
      @(negedge clock);
      if (stall !== 1'b0) begin
        $display("error stall got %h expected 0", stall);
        tb_errors++;
      end
      if (commit_valid !== 1'b0) begin
        $display("error commit_valid got %h expected 0", commit_valid);
        tb_errors++;
      end
    end

    //////////////////////////////////////////////////////////////////////
    // random stream
    for (int n = 0; n < num_insts && !timed_out; n++) begin
      @(negedge clock);
      burst = (n % 64) >= 44;                       // back to back multiplies
      if (!burst && ({$random(seed)} % 4) == 0) begin
        inst_valid = 1'b0;                          // idle gap
        inst_dest  = arch_idx_width'($random(seed));
      end else begin
        r  = {$random(seed)} % 6;
        op = (burst || r < 2) ? op_mul : opcode_e'(r - 2);
        offer_inst(op, {$random(seed)} % 4, {$random(seed)} % 4, {$random(seed)} % 4,
                   timed_out);
        if (timed_out) begin
          $display("stall stayed high, instruction %0d never accepted", n);
          tb_errors++;
        end
      end
    end
    @(negedge clock);
    inst_valid = 1'b0;

    // drain everything that was accepted
    waited = 0;
    while (pending != 0 && waited < drain_timeout) begin
      @(negedge clock);
      waited++;
    end
    if (pending != 0) begin
      $display("drain timed out with %0d instructions not committed", pending);
      tb_errors++;
    end
    repeat (10) @(negedge clock);                   // catch stray extra commits
    if (commit_count != accept_count) begin
      $display("commit count %0d differs from accepted count %0d",
               commit_count, accept_count);
      tb_errors++;
    end

    sva_errors = core_top_i.issue_execute_i.sva_i.fail_count +
                 core_top_i.reorder_buffer_i.sva_i.fail_count;
    $display("accepted %0d committed %0d checker errors %0d tb errors %0d assertion errors %0d",
             accept_count, commit_count, chk_errors, tb_errors, sva_errors);
    if (chk_errors == 0 && tb_errors == 0 && sva_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/core_pkg.sv */
`default_nettype none
//////////////////////////////////////////////////////////////////////
// shared sizes and opcodes for the renaming core slice
// register counts must stay powers of two, as indices wrap naturally
// phys_regs must exceed arch_regs, the spare ones seed the free list
//////////////////////////////////////////////////////////////////////

package core_pkg;

  //////////////////////////////////////////////////////////////////////
  // datapath
  localparam int data_width = 32;   // operand and result width
  localparam int imm_width  = 16;   // op_li immediate, zero extended

  //////////////////////////////////////////////////////////////////////
  // register files
  localparam int arch_regs      = 8;
  localparam int arch_idx_width = 3;
  localparam int phys_regs      = 16;
  localparam int phys_idx_width = 4;

  // free list holds every physical reg not in the map table
  localparam int free_depth       = phys_regs - arch_regs;
  localparam int free_idx_width   = 3;
  localparam int free_count_width = 4;  // 0..free_depth

  //////////////////////////////////////////////////////////////////////
  // reorder buffer
  localparam int rob_depth       = 8;
  localparam int rob_idx_width   = 3;
  localparam int rob_count_width = 4;   // 0..rob_depth

  // issue to result bus, multiply only
  localparam int mul_latency = 4;

  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_xor,
    op_li,    // dest = zero extended imm
    op_mul    // low half of product
  } opcode_e;

endpackage

`default_nettype wire

/* verilog/core_top.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// renaming core slice top, rename then issue then reorder buffer
// an offered instruction is taken when inst_valid is high and stall low
//////////////////////////////////////////////////////////////////////

module core_top import core_pkg::*; (
  input  wire                        clock,
  input  wire                        reset,
  input  wire                        inst_valid,
  input  wire opcode_e               inst_opcode,
  input  wire [arch_idx_width-1:0]   inst_dest,
  input  wire [arch_idx_width-1:0]   inst_src1,
  input  wire [arch_idx_width-1:0]   inst_src2,
  input  wire [imm_width-1:0]        inst_imm,
  output logic                       stall,
  output logic                       commit_valid,
  output logic [arch_idx_width-1:0]  commit_arch_idx,
  output logic [data_width-1:0]      commit_data
);

  // rename to issue and rob
  logic                      ren_valid;
  opcode_e                   ren_opcode;
  logic [arch_idx_width-1:0] ren_dest_arch;
  logic [phys_idx_width-1:0] ren_dest_phys, ren_old_phys;
  logic [phys_idx_width-1:0] ren_src1_phys, ren_src2_phys;
  logic [imm_width-1:0]      ren_imm;
  logic [rob_idx_width-1:0]  ren_tag, ren_rob_idx;
  // back pressure and retire
  logic                      issue_busy, rob_full, free_valid;
  logic [phys_idx_width-1:0] free_phys;
  // result bus
  logic                      cdb_valid;
  logic [rob_idx_width-1:0]  cdb_rob_idx;
  logic [data_width-1:0]     cdb_data;

  rename_stage rename_stage_i (
    .clock, .reset,
    .inst_valid, .inst_opcode, .inst_dest, .inst_src1, .inst_src2, .inst_imm,
    .issue_busy, .rob_full, .ren_rob_idx, .free_valid, .free_phys,
    .stall,
    .ren_valid, .ren_opcode, .ren_dest_arch, .ren_dest_phys, .ren_old_phys,
    .ren_src1_phys, .ren_src2_phys, .ren_imm, .ren_tag
  );

  issue_execute issue_execute_i (
    .clock, .reset,
    .ren_valid, .ren_opcode, .ren_dest_phys, .ren_src1_phys, .ren_src2_phys,
    .ren_imm, .ren_tag,
    .issue_busy, .cdb_valid, .cdb_rob_idx, .cdb_data
  );

  reorder_buffer reorder_buffer_i (
    .clock, .reset,
    .ren_valid, .ren_dest_arch, .ren_dest_phys, .ren_old_phys,
    .cdb_valid, .cdb_rob_idx, .cdb_data,
    .ren_rob_idx, .rob_full, .free_valid, .free_phys,
    .commit_valid, .commit_arch_idx, .commit_data
  );

endmodule

`default_nettype wire

/* verilog/issue_execute.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// physical register file, one entry issue buffer and execute paths
// no result bypass, a source is usable once its ready bit is set
// one result per cycle, multiply results always win the bus
//////////////////////////////////////////////////////////////////////

module issue_execute import core_pkg::*; (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       ren_valid,
  input  wire opcode_e              ren_opcode,
  input  wire [phys_idx_width-1:0]  ren_dest_phys,
  input  wire [phys_idx_width-1:0]  ren_src1_phys,
  input  wire [phys_idx_width-1:0]  ren_src2_phys,
  input  wire [imm_width-1:0]       ren_imm,
  input  wire [rob_idx_width-1:0]   ren_tag,
  output logic                      issue_busy,
  output logic                      cdb_valid,
  output logic [rob_idx_width-1:0]  cdb_rob_idx,
  output logic [data_width-1:0]     cdb_data
);

  logic [data_width-1:0]     regfile [phys_regs];
  logic [phys_regs-1:0]      ready;              // value present

  // issue buffer, only loaded when empty
  logic                      buf_valid;
  opcode_e                   buf_op;
  logic [phys_idx_width-1:0] buf_dest, buf_src1, buf_src2;
  logic [imm_width-1:0]      buf_imm;
  logic [rob_idx_width-1:0]  buf_tag;

  // held entry first, else the incoming packet
  logic                      cand_valid;
  opcode_e                   cand_op;
  logic [phys_idx_width-1:0] cand_dest, cand_src1, cand_src2;
  logic [imm_width-1:0]      cand_imm;
  logic [rob_idx_width-1:0]  cand_tag;
  logic                      srcs_ready, bus_free, can_issue;
  logic [data_width-1:0]     opa, opb, alu_result;

  // execute outputs
  logic                      alu_valid;
  logic [rob_idx_width-1:0]  alu_tag;
  logic [phys_idx_width-1:0] alu_dest;
  logic [data_width-1:0]     alu_data;
  logic [mul_latency-1:0]    mul_valid;          // also the bus slot schedule
  logic [rob_idx_width-1:0]  mul_tag  [mul_latency];
  logic [phys_idx_width-1:0] mul_dest [mul_latency];
  logic [data_width-1:0]     mul_prod [mul_latency];
  logic [phys_idx_width-1:0] cdb_dest;

  assign cand_valid = buf_valid | ren_valid;
  assign cand_op    = buf_valid ? buf_op   : ren_opcode;
  assign cand_dest  = buf_valid ? buf_dest : ren_dest_phys;
  assign cand_src1  = buf_valid ? buf_src1 : ren_src1_phys;
  assign cand_src2  = buf_valid ? buf_src2 : ren_src2_phys;
  assign cand_imm   = buf_valid ? buf_imm  : ren_imm;
  assign cand_tag   = buf_valid ? buf_tag  : ren_tag;

  assign opa = regfile[cand_src1];
  assign opb = regfile[cand_src2];

  // li reads no registers
  assign srcs_ready = (cand_op == op_li) | (ready[cand_src1] & ready[cand_src2]);
  // single cycle op waits if a multiply lands in its result slot
  assign bus_free   = (cand_op == op_mul) | ~mul_valid[mul_latency-2];
  assign can_issue  = cand_valid & srcs_ready & bus_free;
  assign issue_busy = cand_valid & ~can_issue;   // occupied next cycle

  always_comb begin
    case (cand_op)
      op_add:  alu_result = opa + opb;
      op_sub:  alu_result = opa - opb;
      op_xor:  alu_result = opa ^ opb;
      op_li:   alu_result = {{(data_width-imm_width){1'b0}}, cand_imm};
      default: alu_result = '0;                   // op_mul goes the long way
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // control state
  always_ff @(posedge clock) begin
    if (reset) begin
      buf_valid <= 1'b0;
      alu_valid <= 1'b0;
      mul_valid <= '0;
    end else begin
      buf_valid <= issue_busy;
      alu_valid <= can_issue & (cand_op != op_mul);
      mul_valid <= {mul_valid[mul_latency-2:0], can_issue & (cand_op == op_mul)};
    end
  end

  // payload, no reset
  always_ff @(posedge clock) begin
    if (ren_valid) begin                           // buffer is empty here
      buf_op   <= ren_opcode;
      buf_dest <= ren_dest_phys;
      buf_src1 <= ren_src1_phys;
      buf_src2 <= ren_src2_phys;
      buf_imm  <= ren_imm;
      buf_tag  <= ren_tag;
    end
    alu_tag     <= cand_tag;
    alu_dest    <= cand_dest;
    alu_data    <= alu_result;
    mul_tag[0]  <= cand_tag;
    mul_dest[0] <= cand_dest;
    mul_prod[0] <= opa * opb;                      // low half kept
    for (int k = 1; k < mul_latency; k++) begin
      mul_tag[k]  <= mul_tag[k-1];
      mul_dest[k] <= mul_dest[k-1];
      mul_prod[k] <= mul_prod[k-1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // result bus and writeback
  assign cdb_valid   = mul_valid[mul_latency-1] | alu_valid;
  assign cdb_rob_idx = mul_valid[mul_latency-1] ? mul_tag[mul_latency-1]  : alu_tag;
  assign cdb_dest    = mul_valid[mul_latency-1] ? mul_dest[mul_latency-1] : alu_dest;
  assign cdb_data    = mul_valid[mul_latency-1] ? mul_prod[mul_latency-1] : alu_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int p = 0; p < phys_regs; p++) begin
        regfile[p] <= '0;
      end
      ready <= '1;
    end else begin
      if (ren_valid) ready[ren_dest_phys] <= 1'b0;  // new producer pending
      if (cdb_valid) begin
        regfile[cdb_dest] <= cdb_data;
        ready[cdb_dest]   <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/rename_stage.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// rename stage with map table, free list and rename register
// the source must hold an instruction while stall is high
// no recovery, so the map table is speculative only
//////////////////////////////////////////////////////////////////////

module rename_stage import core_pkg::*; (
  input  wire                        clock,
  input  wire                        reset,
  // instruction strobe
  input  wire                        inst_valid,
  input  wire opcode_e               inst_opcode,
  input  wire [arch_idx_width-1:0]   inst_dest,
  input  wire [arch_idx_width-1:0]   inst_src1,
  input  wire [arch_idx_width-1:0]   inst_src2,
  input  wire [imm_width-1:0]        inst_imm,
  // back pressure and retire
  input  wire                        issue_busy,
  input  wire                        rob_full,
  input  wire [rob_idx_width-1:0]    ren_rob_idx,
  input  wire                        free_valid,
  input  wire [phys_idx_width-1:0]   free_phys,
  output logic                       stall,
  // renamed packet
  output logic                       ren_valid,
  output opcode_e                    ren_opcode,
  output logic [arch_idx_width-1:0]  ren_dest_arch,
  output logic [phys_idx_width-1:0]  ren_dest_phys,
  output logic [phys_idx_width-1:0]  ren_old_phys,
  output logic [phys_idx_width-1:0]  ren_src1_phys,
  output logic [phys_idx_width-1:0]  ren_src2_phys,
  output logic [imm_width-1:0]       ren_imm,
  output logic [rob_idx_width-1:0]   ren_tag
);

  logic [phys_idx_width-1:0]   map_table [arch_regs];   // arch -> phys
  logic [phys_idx_width-1:0]   fl_mem [free_depth];     // circular free list
  logic [free_idx_width-1:0]   fl_head;                 // pop side
  logic [free_idx_width-1:0]   fl_tail;                 // push side
  logic [free_count_width-1:0] fl_count;
  logic                        accept;

  // no free reg, full rob or a blocked issue buffer
  assign stall  = (fl_count == '0) | issue_busy | rob_full;
  assign accept = inst_valid & ~stall;

  //////////////////////////////////////////////////////////////////////
  // map table and free list
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < arch_regs; r++) begin
        map_table[r] <= phys_idx_width'(r);        // identity map
      end
      for (int i = 0; i < free_depth; i++) begin
        fl_mem[i] <= phys_idx_width'(arch_regs + i); // spares
      end
      fl_head  <= '0;
      fl_tail  <= '0;
      fl_count <= free_count_width'(free_depth);
    end else begin
      if (accept) begin
        map_table[inst_dest] <= fl_mem[fl_head];   // new mapping
        fl_head <= fl_head + 1'b1;
      end
      if (free_valid) begin                        // released at retire
        fl_mem[fl_tail] <= free_phys;
        fl_tail <= fl_tail + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      fl_count <= fl_count + free_count_width'(free_valid)
                           - free_count_width'(accept);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // rename pipeline register
  always_ff @(posedge clock) begin
    if (reset) begin
      ren_valid <= 1'b0;
    end else begin
      ren_valid <= accept;                         // one cycle pulse
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      ren_opcode    <= inst_opcode;
      ren_dest_arch <= inst_dest;
      ren_dest_phys <= fl_mem[fl_head];
      ren_old_phys  <= map_table[inst_dest];       // freed when this retires
      ren_src1_phys <= map_table[inst_src1];
      ren_src2_phys <= map_table[inst_src2];
      ren_imm       <= inst_imm;
      ren_tag       <= ren_rob_idx;                // rob slot it will occupy
    end
  end

endmodule

`default_nettype wire

/* verilog/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// in order tracking and retire, one commit per cycle at most
// ren_rob_idx and rob_full count the packet already in rename
//////////////////////////////////////////////////////////////////////

module reorder_buffer import core_pkg::*; (
  input  wire                        clock,
  input  wire                        reset,
  input  wire                        ren_valid,
  input  wire [arch_idx_width-1:0]   ren_dest_arch,
  input  wire [phys_idx_width-1:0]   ren_dest_phys,
  input  wire [phys_idx_width-1:0]   ren_old_phys,
  input  wire                        cdb_valid,
  input  wire [rob_idx_width-1:0]    cdb_rob_idx,
  input  wire [data_width-1:0]       cdb_data,
  output logic [rob_idx_width-1:0]   ren_rob_idx,
  output logic                       rob_full,
  output logic                       free_valid,
  output logic [phys_idx_width-1:0]  free_phys,
  output logic                       commit_valid,
  output logic [arch_idx_width-1:0]  commit_arch_idx,
  output logic [data_width-1:0]      commit_data
);

  logic [arch_idx_width-1:0]  ent_arch [rob_depth];
  logic [phys_idx_width-1:0]  ent_old  [rob_depth];  // previous mapping
  logic [data_width-1:0]      ent_data [rob_depth];
  logic [rob_depth-1:0]       done;
  logic [rob_idx_width-1:0]   head, tail;
  logic [rob_count_width-1:0] count;
  logic                       retire;

  // slot for the next accepted instruction, past any pending one
  assign ren_rob_idx = tail + rob_idx_width'(ren_valid);
  assign rob_full    = (count + rob_count_width'(ren_valid)) >=
                       rob_count_width'(rob_depth);
  assign retire      = (count != '0) & done[head];

  //////////////////////////////////////////////////////////////////////
  // pointers and flags
  always_ff @(posedge clock) begin
    if (reset) begin
      head         <= '0;
      tail         <= '0;
      count        <= '0;
      done         <= '0;
      commit_valid <= 1'b0;
      free_valid   <= 1'b0;
    end else begin
      if (ren_valid) begin
        done[tail] <= 1'b0;
        tail       <= tail + 1'b1;
      end
      if (cdb_valid) done[cdb_rob_idx] <= 1'b1;    // never the tail slot
      if (retire) head <= head + 1'b1;
      count        <= count + rob_count_width'(ren_valid)
                            - rob_count_width'(retire);
      commit_valid <= retire;
      free_valid   <= retire;                      // old mapping is dead now
    end
  end

  // entry payload and commit data
  always_ff @(posedge clock) begin
    if (ren_valid) begin
      ent_arch[tail] <= ren_dest_arch;
      ent_old[tail]  <= ren_old_phys;
    end
    if (cdb_valid) ent_data[cdb_rob_idx] <= cdb_data;
    if (retire) begin
      commit_arch_idx <= ent_arch[head];
      commit_data     <= ent_data[head];
      free_phys       <= ent_old[head];
    end
  end

endmodule

`default_nettype wire
